// ==== blas_engine.f ====
src/pkg_mpu.sv
src/pkg_tpu.sv
src/instr_queue.sv
src/issue_unit.sv
src/tpu_exec.sv
src/commit_unit.sv
src/blas_engine.sv
test/tb_blas_engine.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_blas_engine \
	-f blas_engine.f -o sim_blas_engine \
	&& ./obj_dir/sim_blas_engine | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
	&& { echo "run.sh: run passed"; exit 0; } \
	|| { echo "run.sh: run failed"; exit 1; }

// ==== test/tb_blas_engine.sv ====
`timescale 1ns/1ns

module tb_blas_engine
	import pkg_tpu::*;
	import pkg_mpu::*;
();

	localparam int	RESET_CYCLES	= 16;
	localparam int	MAX_INFLIGHT	= 8;
	localparam int	NUM_CMDS		= 70;		// 2 + 6 + 12 + 50
	localparam int	WATCHDOG_NS		= RESET_CYCLES * 10 + NUM_CMDS * 200;

	logic			clock;
	logic			rst_n;
	logic			cmd_req;
	op_t			cmd_op;
	data_t			cmd_a;
	data_t			cmd_x;
	data_t			cmd_y;
	logic			cmd_ack;
	logic			res_req;
	data_t			res_data;
	issue_no_t		res_issue_no;
	logic			res_ack;
	logic			idle;

	// Reference model state
	data_t			ref_acc;
	issue_no_t		ref_issue_no;
	data_t			exp_data_q[$];
	issue_no_t		exp_issue_q[$];

	logic	[31:0]	lcg_state;
	int				n_ok;
	int				n_bad;
	int				accepted;

	blas_engine DUT (
		.clock(clock), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_op(cmd_op),
		.cmd_a(cmd_a), .cmd_x(cmd_x), .cmd_y(cmd_y), .cmd_ack(cmd_ack),
		.res_req(res_req), .res_data(res_data), .res_issue_no(res_issue_no),
		.res_ack(res_ack), .idle(idle)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the DUT stopped answering the handshakes");
		$display("Simulation FAILED");
		$finish;
	end

	function automatic data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			n_bad++;
		end else begin
			n_ok++;
		end
	endtask

	// Expected result in issue order
	task automatic model_push(input op_t op, input data_t a, input data_t x, input data_t y);
		data_t prod;
		data_t val;
		prod = a * x;
		case (op)
			OP_MUL:		val = prod;
			OP_AXPY:	val = prod + y;
			OP_MAC: begin
				ref_acc	= ref_acc + prod;
				val		= ref_acc;
			end
			default: begin
				val		= ref_acc;
				ref_acc	= '0;
			end
		endcase
		exp_data_q.push_back(val);
		exp_issue_q.push_back(ref_issue_no);
		ref_issue_no = ref_issue_no + 1'b1;
	endtask

	////////////////////////////////////////
	// Host handshakes

	task automatic send_cmd(input op_t op, input data_t a, input data_t x, input data_t y);
		model_push(op, a, x, y);
		cmd_op	= op;
		cmd_a	= a;
		cmd_x	= x;
		cmd_y	= y;
		cmd_req	= 1'b1;
		do @(posedge clock) #1; while (!cmd_ack);
		cmd_req	= 1'b0;
		do @(posedge clock) #1; while (cmd_ack);
	endtask

	task automatic get_result(input int hold_cycles);
		do @(posedge clock) #1; while (!res_req);
		if (exp_data_q.size() == 0) begin
			$display("Result arrived with no command outstanding at %0t ns", $time);
			n_bad++;
		end else begin
			check("res_data", exp_data_q.pop_front(), res_data);
			check("res_issue_no", 16'(exp_issue_q.pop_front()), 16'(res_issue_no));
		end
		repeat (hold_cycles) @(posedge clock) #1;
		res_ack = 1'b1;
		do @(posedge clock) #1; while (res_req);
		res_ack = 1'b0;
	endtask

	task automatic run_op(input op_t op, input data_t a, input data_t x, input data_t y);
		send_cmd(op, a, x, y);
		get_result(0);
	endtask

	task automatic report_test(input string name, input int bad_before);
		if (n_bad == bad_before)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d mismatches", name, n_bad - bad_before);
	endtask

	////////////////////////////////////////
	// Directed tests

	task automatic after_reset();
		int b;
		b = n_bad;
		check("idle", 16'h1, 16'(idle));
		check("cmd_ack", 16'h0, 16'(cmd_ack));
		check("res_req", 16'h0, 16'(res_req));
		report_test("reset", b);
	endtask

	task automatic mul_axpy();
		int b;
		b = n_bad;
		run_op(OP_MUL, 16'd300, 16'd300, 16'd0);		// Wraps to 24464
		run_op(OP_AXPY, 16'hffff, 16'd2, 16'd5);
		report_test("mul_axpy", b);
	endtask

	task automatic mac_then_clear();
		int b;
		b = n_bad;
		run_op(OP_MAC, 16'd3, 16'd4, 16'd0);
		run_op(OP_MAC, 16'd10, 16'd10, 16'd0);
		run_op(OP_MAC, 16'd256, 16'd256, 16'd0);		// Product wraps to zero
		run_op(OP_MAC, 16'd7, 16'd9, 16'd0);
		run_op(OP_RDACC, 16'd0, 16'd0, 16'd0);
		run_op(OP_RDACC, 16'd0, 16'd0, 16'd0);			// Cleared by the first read
		report_test("mac", b);
	endtask

	task automatic backpressure();
		int b;
		b = n_bad;
		accepted = 0;
		fork
			begin
				for (int i = 0; i < 12; i++) begin
					send_cmd(OP_AXPY, 16'(i + 1), 16'(i + 2), 16'(i * 3));
					accepted++;
				end
			end
			begin
				while (accepted < MAX_INFLIGHT) @(posedge clock);
				repeat (20) @(posedge clock);
				#1;
				check("accepted", 16'(MAX_INFLIGHT), 16'(accepted));
				check("cmd_req", 16'h1, 16'(cmd_req));
				check("cmd_ack", 16'h0, 16'(cmd_ack));
				check("idle", 16'h0, 16'(idle));	// Results still held
				for (int i = 0; i < 12; i++) get_result(2);
			end
		join
		report_test("backpressure", b);
	endtask

	task automatic random_ops();
		int b;
		data_t r;
		op_t op;
		b = n_bad;
		for (int i = 0; i < 50; i++) begin
			r = lcg_next();
			op = (i < 4) ? op_t'(i[1:0]) : op_t'(r[1:0]);	// All four opcodes first
			run_op(op, lcg_next(), lcg_next(), lcg_next());
		end
		report_test("random", b);
	endtask

	task automatic idle_after_drain();
		int b;
		int n;
		b = n_bad;
		n = 0;
		while (!idle && n < 10) begin
			@(posedge clock) #1;
			n++;
		end
		if (!idle) begin
			$display("idle stayed low after every result was acknowledged");
			n_bad++;
		end
		report_test("idle", b);
	endtask

	initial begin
		rst_n			= 1'b0;
		cmd_req			= 1'b0;
		cmd_op			= OP_MUL;
		cmd_a			= '0;
		cmd_x			= '0;
		cmd_y			= '0;
		res_ack			= 1'b0;
		ref_acc			= '0;
		ref_issue_no	= '0;
		lcg_state		= 32'd45;
		n_ok			= 0;
		n_bad			= 0;
		accepted		= 0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst_n = 1'b1;
		@(posedge clock) #1;

		after_reset();
		mul_axpy();
		mac_then_clear();
		backpressure();
		random_ops();
		idle_after_drain();

		$display("Checks: %0d passed, %0d failed", n_ok, n_bad);
		if (n_bad == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src/blas_engine.sv ====
`timescale 1ns/1ns

module blas_engine
	import pkg_tpu::*;
	import pkg_mpu::*;
#(
	parameter int	QUEUE_DEPTH		= 4,
	parameter int	MAX_INFLIGHT	= 8
) (
	input						clock,
	input						rst_n,
	input						cmd_req,
	input	op_t				cmd_op,
	input	data_t				cmd_a,
	input	data_t				cmd_x,
	input	data_t				cmd_y,
	output						cmd_ack,
	output						res_req,
	output	data_t				res_data,
	output	issue_no_t			res_issue_no,
	input						res_ack,
	output						idle
);

	logic						iq_push;
	logic						iq_full;
	logic						iq_pop;
	logic						iq_empty;
	instr_t						iq_push_data;
	instr_t						iq_head;

	logic						rq_push;
	logic						rq_full;
	logic						rq_pop;
	logic						rq_empty;
	result_t					rq_push_data;
	result_t					rq_head;

	logic						commit;

	issue_unit #(
		.MAX_INFLIGHT(	MAX_INFLIGHT	)
	) issue_unit (
		.clock(			clock			),	.rst_n(			rst_n			),
		.cmd_req(		cmd_req			),	.cmd_op(		cmd_op			),
		.cmd_a(			cmd_a			),	.cmd_x(			cmd_x			),
		.cmd_y(			cmd_y			),	.cmd_ack(		cmd_ack			),
		.push(			iq_push			),	.push_data(		iq_push_data	),
		.full(			iq_full			),	.commit(		commit			),
		.idle(			idle			)
	);

	instr_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(instr_t)) cmd_queue (
		.clock(clock), .rst_n(rst_n), .push(iq_push), .push_data(iq_push_data),
		.full(iq_full), .pop(iq_pop), .pop_data(iq_head), .empty(iq_empty)
	);

	tpu_exec tpu_exec (
		.clock(clock), .rst_n(rst_n), .instr_valid(!iq_empty), .instr(iq_head),
		.instr_pop(iq_pop), .res_push(rq_push), .res_data(rq_push_data), .res_full(rq_full)
	);

	instr_queue #(.DEPTH(QUEUE_DEPTH), .payload_t(result_t)) res_queue (
		.clock(clock), .rst_n(rst_n), .push(rq_push), .push_data(rq_push_data),
		.full(rq_full), .pop(rq_pop), .pop_data(rq_head), .empty(rq_empty)
	);

	commit_unit commit_unit (
		.clock(clock), .rst_n(rst_n), .empty(rq_empty), .head(rq_head), .pop(rq_pop),
		.res_req(res_req), .res_data(res_data), .res_issue_no(res_issue_no),
		.res_ack(res_ack), .commit(commit)
	);

endmodule

// ==== src/commit_unit.sv ====
`timescale 1ns/1ns

module commit_unit
	import pkg_tpu::*;
	import pkg_mpu::*;
(
	input						clock,
	input						rst_n,
	input						empty,
	input	result_t			head,
	output						pop,
	output	logic				res_req,
	output	data_t				res_data,
	output	issue_no_t			res_issue_no,
	input						res_ack,
	output	logic				commit
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_HI,								// res_req up, waiting for ack
		ST_WAIT_LO								// Waiting for ack to drop
	} state_t;

	state_t						state;

	assign pop = (state == ST_IDLE) && !empty;

	always_ff @(posedge clock) begin
		if (pop) begin
			res_data		<= head.data;
			res_issue_no	<= head.issue_no;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state	<= ST_IDLE;
			res_req	<= 1'b0;
			commit	<= 1'b0;
		end else begin
			commit <= 1'b0;
			case (state)
				ST_IDLE: if (pop) begin
					res_req	<= 1'b1;
					state	<= ST_WAIT_HI;
				end
				ST_WAIT_HI: if (res_ack) begin
					res_req	<= 1'b0;
					commit	<= 1'b1;			// Frees one in-flight slot
					state	<= ST_WAIT_LO;
				end
				default: if (!res_ack) state <= ST_IDLE;
			endcase
		end
	end

	a_req_hold: assert property (
		@(posedge clock) disable iff (!rst_n)
		res_req && !res_ack |=> res_req && $stable(res_data) && $stable(res_issue_no)
	) else $error("commit_unit: result changed before res_ack");

endmodule

// ==== src/tpu_exec.sv ====
`timescale 1ns/1ns

module tpu_exec
	import pkg_tpu::*;
	import pkg_mpu::*;
(
	input						clock,
	input						rst_n,
	input						instr_valid,
	input	instr_t				instr,
	output						instr_pop,
	output						res_push,
	output	result_t			res_data,
	input						res_full
);

	// Stage 1 registers
	logic						s1_valid;
	op_t						s1_op;
	data_t						s1_prod;
	data_t						s1_y;
	issue_no_t					s1_issue_no;

	// Stage 2 registers
	logic						s2_valid;
	result_t					s2_result;

	data_t						acc;
	data_t						acc_next;
	data_t						s2_val;
	logic						s2_ready;
	logic						s1_ready;

	assign s2_ready		= !s2_valid || !res_full;
	assign s1_ready		= !s1_valid || s2_ready;	// Stall only when both full
	assign instr_pop	= instr_valid && s1_ready;
	assign res_push		= s2_valid && !res_full;
	assign res_data		= s2_result;

	always_comb begin
		acc_next = acc;
		case (s1_op)
			OP_MUL:		s2_val = s1_prod;
			OP_AXPY:	s2_val = s1_prod + s1_y;
			OP_MAC: begin
				s2_val		= acc + s1_prod;
				acc_next	= acc + s1_prod;
			end
			default: begin						// OP_RDACC
				s2_val		= acc;
				acc_next	= '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			s1_valid	<= 1'b0;
			s2_valid	<= 1'b0;
			acc			<= '0;
		end else begin
			if (s1_ready) s1_valid <= instr_pop;
			if (s2_ready) s2_valid <= s1_valid;
			if (s1_valid && s2_ready) acc <= acc_next;
		end
	end

	always_ff @(posedge clock) begin
		if (instr_pop) begin
			s1_op		<= instr.op;
			s1_prod		<= instr.a * instr.x;	// Low 16 bits kept
			s1_y		<= instr.y;
			s1_issue_no	<= instr.issue_no;
		end
		if (s1_valid && s2_ready) begin
			s2_result	<= '{issue_no: s1_issue_no, data: s2_val};
		end
	end

endmodule

// ==== src/issue_unit.sv ====
`timescale 1ns/1ns

module issue_unit
	import pkg_tpu::*;
	import pkg_mpu::*;
#(
	parameter int	MAX_INFLIGHT	= 8
) (
	input						clock,
	input						rst_n,
	input						cmd_req,			// Four-phase from host
	input	op_t				cmd_op,
	input	data_t				cmd_a,
	input	data_t				cmd_x,
	input	data_t				cmd_y,
	output	logic				cmd_ack,
	output						push,
	output	instr_t				push_data,
	input						full,
	input						commit,				// One per acknowledged result
	output						idle
);

	issue_no_t					issue_no;
	logic	[3:0]				inflight;
	logic						can_issue;

	assign can_issue	= !full && (inflight < 4'(MAX_INFLIGHT));

	// Accept only on a fresh request
	assign push			= cmd_req && !cmd_ack && can_issue;
	assign idle			= (inflight == '0);

	assign push_data	= '{op: cmd_op, a: cmd_a, x: cmd_x, y: cmd_y, issue_no: issue_no};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cmd_ack		<= 1'b0;
			issue_no	<= '0;
		end else begin
			if (push) begin
				cmd_ack		<= 1'b1;
				issue_no	<= issue_no + 1'b1;
			end else if (cmd_ack && !cmd_req) begin
				cmd_ack		<= 1'b0;			// Return to zero
			end
		end
	end

	////////////////////////////////////////
	// In-flight tracking

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			inflight <= '0;
		end else begin
			case ({push, commit})
				2'b10:		inflight <= inflight + 1'b1;
				2'b01:		inflight <= inflight - 1'b1;
				default:	inflight <= inflight;
			endcase
		end
	end

	a_inflight_limit: assert property (
		@(posedge clock) disable iff (!rst_n) inflight <= 4'(MAX_INFLIGHT)
	) else $error("issue_unit: in-flight count above limit");

endmodule

// ==== src/instr_queue.sv ====
`timescale 1ns/1ns

module instr_queue #(
	parameter int	DEPTH		= 4,
	parameter type	payload_t	= logic [7:0]
) (
	input						clock,
	input						rst_n,
	input						push,
	input	payload_t			push_data,
	output						full,
	input						pop,
	output	payload_t			pop_data,
	output						empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t					mem		[DEPTH];
	logic	[AW-1:0]			wr_ptr;
	logic	[AW-1:0]			rd_ptr;
	logic	[CW-1:0]			count;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full		= (count == CW'(DEPTH));
	assign empty	= (count == '0);
	assign pop_data	= mem[rd_ptr];				// Head is always visible

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Both or neither
			endcase
		end
	end

	////////////////////////////////////////
	// Producer and consumer must respect the flags

	a_no_overflow: assert property (
		@(posedge clock) disable iff (!rst_n) full |-> !push
	) else $error("instr_queue: push while full");

	a_no_underflow: assert property (
		@(posedge clock) disable iff (!rst_n) empty |-> !pop
	) else $error("instr_queue: pop while empty");

endmodule

// ==== src/pkg_tpu.sv ====
package pkg_tpu;

	import pkg_mpu::issue_no_t;

	////////////////////////////////////////
	// Datapath

	typedef logic [15:0]	data_t;					// Wraps modulo 2^16

	typedef enum logic [1:0] {
		OP_MUL		= 2'd0,							// a*x
		OP_AXPY		= 2'd1,							// a*x + y
		OP_MAC		= 2'd2,							// acc += a*x
		OP_RDACC	= 2'd3							// Read then clear acc
	} op_t;

	////////////////////////////////////////
	// Instruction word

	typedef struct packed {
		op_t				op;
		data_t				a;
		data_t				x;
		data_t				y;
		issue_no_t			issue_no;
	} instr_t;

endpackage

// ==== src/pkg_mpu.sv ====
package pkg_mpu;

	////////////////////////////////////////
	// Issue numbering

	typedef logic [3:0]		issue_no_t;				// Wraps after 15

	////////////////////////////////////////
	// Commit record

	// Width matches pkg_tpu::data_t
	typedef struct packed {
		issue_no_t			issue_no;
		logic [15:0]		data;
	} result_t;

endpackage
